// ==== src/lwc_api_pkg.sv ====
// ############################
// External protocol definitions
// Bus word and length types, opcodes, header field positions
// and the stream structs of the cipher and DO ports
// ############################

package lwc_api_pkg;

    // Bus and segment widths
    typedef logic [31:0] word_t;
    typedef logic [15:0] length_t;
    typedef logic [2:0]  nbytes_t;
    typedef logic [3:0]  opcode_t;

    // Instruction opcodes
    localparam opcode_t OP_ACTIVATE_KEY = 4'b0111;
    localparam opcode_t OP_LOAD_KEY     = 4'b0100;
    localparam opcode_t OP_HASH         = 4'b1000;

    // Segment types written on DO
    localparam opcode_t HDR_HASH_VALUE = 4'b1001;
    localparam opcode_t STATUS_SUCCESS = 4'b1110;

    // Header word layout
    localparam int HDR_TYPE_MSB = 31;
    localparam int HDR_TYPE_LSB = 28;
    localparam int HDR_EOT_BIT  = 25;
    localparam int HDR_LAST_BIT = 24;
    localparam int HDR_LEN_MSB  = 15;
    localparam int HDR_LEN_LSB  = 0;

    // Bytes per bus word and per hash digest
    localparam length_t WORD_BYTES = 16'd4;
    localparam length_t HASH_BYTES = 16'd32;

    typedef enum logic {
        DIN_KEY  = 1'b0,
        DIN_HASH = 1'b1
    } din_kind_e;

    // Word towards the cipher core, tagged with its byte count and end flags
    typedef struct packed {
        word_t     data;
        din_kind_e kind;
        nbytes_t   nbytes;
        logic      last;
        logic      eot;
    } cipher_din_t;

    // Cipher output and DO word
    typedef struct packed {
        word_t data;
        logic  last;
    } out_word_t;

endpackage

// ==== src/lwc_ctrl_pkg.sv ====
// ############################
// Internal controller definitions
// FSM state enums, segment command and DO message code
// ############################

package lwc_ctrl_pkg;

    import lwc_api_pkg::*;

    // Operation sequencer states
    typedef enum logic [2:0] {
        FLOW_IDLE,
        FLOW_KEY_INST,
        FLOW_KEY_SEG,
        FLOW_HASH_HDR,
        FLOW_HASH_SEG,
        FLOW_HASH_OUT,
        FLOW_STATUS
    } flow_state_e;

    // Segment loader states
    typedef enum logic [1:0] {
        LD_IDLE,
        LD_HEADER,
        LD_DATA,
        LD_FINAL
    } loader_state_e;

    // Issued with the segment start pulse
    typedef struct packed {
        din_kind_e kind;
    } seg_cmd_t;

    // Message requested from the DO writer
    typedef enum logic [1:0] {
        MSG_NONE,
        MSG_HASH_HDR,
        MSG_STATUS
    } do_msg_e;

endpackage

// ==== src/lwc_segment_loader.sv ====
// ############################
// Segment loader
// Parses one segment header, counts bytes down and forwards
// tagged data words, or one empty block for a zero length
// ############################

`timescale 1ns/10ps

module lwc_segment_loader
    import lwc_api_pkg::*;
    import lwc_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        seg_start,
    input  seg_cmd_t    seg_cmd,
    input  word_t       seg_in,
    input  logic        seg_in_valid,
    output logic        seg_in_ready,
    output cipher_din_t cipher_din,
    output logic        cipher_din_valid,
    input  logic        cipher_din_ready,
    output logic        seg_done,
    output logic        seg_eot
);

    loader_state_e state;
    loader_state_e state_next;
    length_t       remaining;
    length_t       hdr_len;
    logic          eot_q;
    din_kind_e     kind_q;
    logic          out_free;
    logic          hdr_take;
    logic          hdr_empty;
    logic          data_take;
    logic          final_word;

    // One-entry output register towards the cipher
    assign out_free = !cipher_din_valid || cipher_din_ready;

    assign seg_in_ready = (state == LD_HEADER) || ((state == LD_DATA) && out_free);
    assign hdr_take     = (state == LD_HEADER) && seg_in_valid;
    assign hdr_len      = seg_in[HDR_LEN_MSB:HDR_LEN_LSB];
    assign hdr_empty    = hdr_take && (hdr_len == '0);
    assign data_take    = (state == LD_DATA) && seg_in_valid && out_free;
    assign final_word   = (remaining <= WORD_BYTES);
    assign seg_eot      = eot_q;

    always_comb begin
        state_next = state;
        case (state)
            LD_IDLE: begin
                if (seg_start) begin
                    state_next = LD_HEADER;
                end
            end
            LD_HEADER: begin
                if (hdr_empty) begin
                    state_next = LD_FINAL;
                end else if (hdr_take) begin
                    state_next = LD_DATA;
                end
            end
            LD_DATA: begin
                if (data_take && final_word) begin
                    state_next = LD_FINAL;
                end
            end
            // Final word or empty block waits for the cipher
            LD_FINAL: begin
                if (cipher_din_valid && cipher_din_ready) begin
                    state_next = LD_IDLE;
                end
            end
            default: begin
                state_next = LD_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state            <= LD_IDLE;
            cipher_din_valid <= 1'b0;
            seg_done         <= 1'b0;
            eot_q            <= 1'b0;
            remaining        <= '0;
        end else begin
            state    <= state_next;
            seg_done <= (state == LD_FINAL) && cipher_din_valid && cipher_din_ready;
            if (hdr_empty || data_take) begin
                cipher_din_valid <= 1'b1;
            end else if (cipher_din_ready) begin
                cipher_din_valid <= 1'b0;
            end
            if (hdr_take) begin
                eot_q     <= seg_in[HDR_EOT_BIT];
                remaining <= hdr_len;
            end else if (data_take && !final_word) begin
                remaining <= remaining - WORD_BYTES;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (seg_start) begin
            kind_q <= seg_cmd.kind;
        end
        if (hdr_empty) begin
            cipher_din.data   <= '0;
            cipher_din.kind   <= kind_q;
            cipher_din.nbytes <= '0;
            cipher_din.last   <= 1'b1;
            cipher_din.eot    <= seg_in[HDR_EOT_BIT];
        end else if (data_take) begin
            cipher_din.data   <= seg_in;
            cipher_din.kind   <= kind_q;
            // Partial count only on the closing word
            cipher_din.nbytes <= final_word ? nbytes_t'(remaining) : nbytes_t'(WORD_BYTES);
            cipher_din.last   <= final_word;
            cipher_din.eot    <= final_word && eot_q;
        end
    end

endmodule

// ==== src/lwc_operation_flow.sv ====
// ############################
// Operation flow
// Instruction dispatch, PDI/SDI routing to the loader
// and the segment and message sequence per operation
// ############################

`timescale 1ns/10ps

module lwc_operation_flow
    import lwc_api_pkg::*;
    import lwc_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  word_t    pdi,
    input  logic     pdi_valid,
    output logic     pdi_ready,
    input  word_t    sdi,
    input  logic     sdi_valid,
    output logic     sdi_ready,
    output logic     seg_start,
    output seg_cmd_t seg_cmd,
    output word_t    seg_in,
    output logic     seg_in_valid,
    input  logic     seg_in_ready,
    input  logic     seg_done,
    input  logic     seg_eot,
    output do_msg_e  msg,
    output logic     msg_valid,
    input  logic     msg_ready,
    output logic     hash_pass,
    input  logic     hash_done
);

    flow_state_e state;
    flow_state_e state_next;
    logic        armed;
    logic        hdr_sent;
    logic        start_next;
    opcode_t     pdi_op;
    opcode_t     sdi_op;

    assign pdi_op = pdi[HDR_TYPE_MSB:HDR_TYPE_LSB];
    assign sdi_op = sdi[HDR_TYPE_MSB:HDR_TYPE_LSB];

    // Loader stream comes from SDI for keys and PDI for hash data
    assign seg_in       = (state == FLOW_KEY_SEG) ? sdi : pdi;
    assign seg_in_valid = ((state == FLOW_KEY_SEG) && sdi_valid) ||
                          ((state == FLOW_HASH_SEG) && pdi_valid);
    assign seg_cmd.kind = (state == FLOW_KEY_SEG) ? DIN_KEY : DIN_HASH;

    // Instruction words are held off until the first cycle after reset has passed
    assign pdi_ready = ((state == FLOW_IDLE) && armed) ||
                       ((state == FLOW_HASH_SEG) && seg_in_ready);
    assign sdi_ready = (state == FLOW_KEY_INST) ||
                       ((state == FLOW_KEY_SEG) && seg_in_ready);

    assign hash_pass = (state == FLOW_HASH_OUT);

    always_comb begin
        msg       = MSG_NONE;
        msg_valid = 1'b0;
        if ((state == FLOW_HASH_HDR) && !hdr_sent) begin
            msg       = MSG_HASH_HDR;
            msg_valid = 1'b1;
        end else if (state == FLOW_STATUS) begin
            msg       = MSG_STATUS;
            msg_valid = 1'b1;
        end
    end

    always_comb begin
        state_next = state;
        start_next = 1'b0;
        case (state)
            FLOW_IDLE: begin
                if (armed && pdi_valid) begin
                    case (pdi_op)
                        OP_ACTIVATE_KEY: state_next = FLOW_KEY_INST;
                        OP_HASH:         state_next = FLOW_HASH_HDR;
                        default:         state_next = FLOW_IDLE;
                    endcase
                end
            end
            FLOW_KEY_INST: begin
                if (sdi_valid && (sdi_op == OP_LOAD_KEY)) begin
                    state_next = FLOW_KEY_SEG;
                    start_next = 1'b1;
                end else if (sdi_valid) begin
                    state_next = FLOW_IDLE;
                end
            end
            FLOW_KEY_SEG: begin
                if (seg_done && seg_eot) begin
                    state_next = FLOW_IDLE;
                end else if (seg_done) begin
                    start_next = 1'b1;
                end
            end
            // Second ready after the header was taken means it is leaving on DO
            FLOW_HASH_HDR: begin
                if (hdr_sent && msg_ready) begin
                    state_next = FLOW_HASH_SEG;
                    start_next = 1'b1;
                end
            end
            FLOW_HASH_SEG: begin
                if (seg_done && seg_eot) begin
                    state_next = FLOW_HASH_OUT;
                end else if (seg_done) begin
                    start_next = 1'b1;
                end
            end
            FLOW_HASH_OUT: begin
                if (hash_done) begin
                    state_next = FLOW_STATUS;
                end
            end
            FLOW_STATUS: begin
                if (msg_ready) begin
                    state_next = FLOW_IDLE;
                end
            end
            default: begin
                state_next = FLOW_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= FLOW_IDLE;
            armed     <= 1'b0;
            hdr_sent  <= 1'b0;
            seg_start <= 1'b0;
        end else begin
            state     <= state_next;
            armed     <= 1'b1;
            seg_start <= start_next;
            hdr_sent  <= (state_next == FLOW_HASH_HDR) && (hdr_sent || (msg_valid && msg_ready));
        end
    end

endmodule

// ==== src/lwc_do_writer.sv ====
// ############################
// DO writer
// Builds hash header and status words, passes hash words
// through the same one-entry output register
// ############################

`timescale 1ns/10ps

module lwc_do_writer
    import lwc_api_pkg::*;
    import lwc_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  do_msg_e   msg,
    input  logic      msg_valid,
    output logic      msg_ready,
    input  logic      hash_pass,
    input  out_word_t cipher_dout,
    input  logic      cipher_dout_valid,
    output logic      cipher_dout_ready,
    output logic      hash_done,
    output out_word_t do_word,
    output logic      do_valid,
    input  logic      do_ready
);

    out_word_t msg_word;
    logic      out_free;
    logic      msg_take;
    logic      hash_take;

    assign out_free          = !do_valid || do_ready;
    assign msg_ready         = out_free;
    assign cipher_dout_ready = hash_pass && out_free;
    assign msg_take          = msg_valid && out_free;
    assign hash_take         = cipher_dout_valid && cipher_dout_ready;

    always_comb begin
        msg_word = '0;
        case (msg)
            MSG_HASH_HDR: begin
                msg_word.data[HDR_TYPE_MSB:HDR_TYPE_LSB] = HDR_HASH_VALUE;
                msg_word.data[HDR_EOT_BIT]               = 1'b1;
                msg_word.data[HDR_LAST_BIT]              = 1'b1;
                msg_word.data[HDR_LEN_MSB:HDR_LEN_LSB]   = HASH_BYTES;
            end
            // Status closes the DO message
            MSG_STATUS: begin
                msg_word.data[HDR_TYPE_MSB:HDR_TYPE_LSB] = STATUS_SUCCESS;
                msg_word.last                            = 1'b1;
            end
            default: begin
                msg_word = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            do_valid  <= 1'b0;
            hash_done <= 1'b0;
        end else begin
            hash_done <= hash_take && cipher_dout.last;
            if (msg_take || hash_take) begin
                do_valid <= 1'b1;
            end else if (do_ready) begin
                do_valid <= 1'b0;
            end
        end
    end

    // Hash words go out with DO last cleared
    always_ff @(posedge clk) begin
        if (msg_take) begin
            do_word <= msg_word;
        end else if (hash_take) begin
            do_word.data <= cipher_dout.data;
            do_word.last <= 1'b0;
        end
    end

endmodule

// ==== src/lwc_ctrl_top.sv ====
// ############################
// LWC controller top level
// Operation flow, segment loader and DO writer
// ############################

`timescale 1ns/10ps

module lwc_ctrl_top
    import lwc_api_pkg::*;
    import lwc_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  word_t       pdi,
    input  logic        pdi_valid,
    output logic        pdi_ready,
    input  word_t       sdi,
    input  logic        sdi_valid,
    output logic        sdi_ready,
    output cipher_din_t cipher_din,
    output logic        cipher_din_valid,
    input  logic        cipher_din_ready,
    input  out_word_t   cipher_dout,
    input  logic        cipher_dout_valid,
    output logic        cipher_dout_ready,
    output out_word_t   do_word,
    output logic        do_valid,
    input  logic        do_ready
);

    // Flow to loader
    logic     seg_start;
    seg_cmd_t seg_cmd;
    word_t    seg_in;
    logic     seg_in_valid;
    logic     seg_in_ready;
    logic     seg_done;
    logic     seg_eot;

    // Flow to writer
    do_msg_e  msg;
    logic     msg_valid;
    logic     msg_ready;
    logic     hash_pass;
    logic     hash_done;

    lwc_operation_flow flow_i (
        .clk          (clk),
        .rst          (rst),
        .pdi          (pdi),
        .pdi_valid    (pdi_valid),
        .pdi_ready    (pdi_ready),
        .sdi          (sdi),
        .sdi_valid    (sdi_valid),
        .sdi_ready    (sdi_ready),
        .seg_start    (seg_start),
        .seg_cmd      (seg_cmd),
        .seg_in       (seg_in),
        .seg_in_valid (seg_in_valid),
        .seg_in_ready (seg_in_ready),
        .seg_done     (seg_done),
        .seg_eot      (seg_eot),
        .msg          (msg),
        .msg_valid    (msg_valid),
        .msg_ready    (msg_ready),
        .hash_pass    (hash_pass),
        .hash_done    (hash_done)
    );

    lwc_segment_loader loader_i (
        .clk              (clk),
        .rst              (rst),
        .seg_start        (seg_start),
        .seg_cmd          (seg_cmd),
        .seg_in           (seg_in),
        .seg_in_valid     (seg_in_valid),
        .seg_in_ready     (seg_in_ready),
        .cipher_din       (cipher_din),
        .cipher_din_valid (cipher_din_valid),
        .cipher_din_ready (cipher_din_ready),
        .seg_done         (seg_done),
        .seg_eot          (seg_eot)
    );

    lwc_do_writer writer_i (
        .clk               (clk),
        .rst               (rst),
        .msg               (msg),
        .msg_valid         (msg_valid),
        .msg_ready         (msg_ready),
        .hash_pass         (hash_pass),
        .cipher_dout       (cipher_dout),
        .cipher_dout_valid (cipher_dout_valid),
        .cipher_dout_ready (cipher_dout_ready),
        .hash_done         (hash_done),
        .do_word           (do_word),
        .do_valid          (do_valid),
        .do_ready          (do_ready)
    );

endmodule

// ==== tb/lwc_ctrl_chk.sv ====
// ############################
// Bound stream checks
// Stall stability on cipher_din and DO,
// quiet outputs in and just after reset
// ############################

`timescale 1ns/10ps

module lwc_ctrl_chk
    import lwc_api_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        pdi_ready,
    input logic        sdi_ready,
    input cipher_din_t cipher_din,
    input logic        cipher_din_valid,
    input logic        cipher_din_ready,
    input logic        cipher_dout_ready,
    input out_word_t   do_word,
    input logic        do_valid,
    input logic        do_ready
);

    logic busy_out;

    assign busy_out = pdi_ready || sdi_ready || cipher_din_valid ||
                      cipher_dout_ready || do_valid;

    // A stalled word keeps its value and its valid
    din_stable: assert property (@(posedge clk) disable iff (!rst)
        cipher_din_valid && !cipher_din_ready |=> cipher_din_valid && $stable(cipher_din))
        else $error("cipher_din changed or dropped valid while stalled");

    do_stable: assert property (@(posedge clk) disable iff (!rst)
        do_valid && !do_ready |=> do_valid && $stable(do_word))
        else $error("do_word changed or dropped valid while stalled");

    reset_quiet: assert property (@(posedge clk) !rst |-> !busy_out)
        else $error("valid or ready output high during reset");

    first_cycle_quiet: assert property (@(posedge clk) $rose(rst) |-> !busy_out)
        else $error("valid or ready output high in the first cycle after reset");

endmodule

bind lwc_ctrl_top lwc_ctrl_chk chk_i (
    .clk               (clk),
    .rst               (rst),
    .pdi_ready         (pdi_ready),
    .sdi_ready         (sdi_ready),
    .cipher_din        (cipher_din),
    .cipher_din_valid  (cipher_din_valid),
    .cipher_din_ready  (cipher_din_ready),
    .cipher_dout_ready (cipher_dout_ready),
    .do_word           (do_word),
    .do_valid          (do_valid),
    .do_ready          (do_ready)
);

// ==== tb/lwc_ctrl_tb.sv ====
// ############################
// Testbench for the LWC controller
// Clock, reset, stimulus, cipher model,
// reference function and transfer monitor
// ############################

`timescale 1ns/10ps

module lwc_ctrl_tb
    import lwc_api_pkg::*;
();

    localparam int          TIMEOUT      = 400;
    localparam logic [31:0] SEED         = 32'h3eed;
    // Segment types are not decoded by the loader
    localparam opcode_t     SEG_TYPE_KEY = 4'hc;
    localparam opcode_t     SEG_TYPE_MSG = 4'h6;

    logic        clk = 1'b0;
    logic        rst;
    word_t       pdi;
    logic        pdi_valid;
    logic        pdi_ready;
    word_t       sdi;
    logic        sdi_valid;
    logic        sdi_ready;
    cipher_din_t cipher_din;
    logic        cipher_din_valid;
    logic        cipher_din_ready = 1'b0;
    out_word_t   cipher_dout = '0;
    logic        cipher_dout_valid = 1'b0;
    logic        cipher_dout_ready;
    out_word_t   do_word;
    logic        do_valid;
    logic        do_ready = 1'b0;

    logic        stall_en;
    logic [31:0] rng_stim;
    logic [31:0] rng_bp = SEED;
    word_t       hash_acc;
    int          do_base;

    // Expected transfers, appended by the stimulus
    cipher_din_t exp_din[$];
    out_word_t   exp_do[$];

    // Monitor counters
    int          din_seen;
    int          do_seen;
    int          do_at_pdi;

    // Cipher model state
    out_word_t   model_out[$];
    int          model_rd;
    word_t       model_acc = '0;

    lwc_ctrl_top dut_i (
        .clk               (clk),
        .rst               (rst),
        .pdi               (pdi),
        .pdi_valid         (pdi_valid),
        .pdi_ready         (pdi_ready),
        .sdi               (sdi),
        .sdi_valid         (sdi_valid),
        .sdi_ready         (sdi_ready),
        .cipher_din        (cipher_din),
        .cipher_din_valid  (cipher_din_valid),
        .cipher_din_ready  (cipher_din_ready),
        .cipher_dout       (cipher_dout),
        .cipher_dout_valid (cipher_dout_valid),
        .cipher_dout_ready (cipher_dout_ready),
        .do_word           (do_word),
        .do_valid          (do_valid),
        .do_ready          (do_ready)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected cipher word idx of a segment of len bytes
    function automatic cipher_din_t expected_din(input word_t data, input din_kind_e kind,
                                                 input int len, input int idx, input logic eot);
        cipher_din_t e;
        int          words;
        int          left;
        words  = (len + 3) / 4;
        left   = len - idx * 4;
        e.kind = kind;
        if (len == 0) begin
            // Empty block
            e.data   = '0;
            e.nbytes = '0;
            e.last   = 1'b1;
            e.eot    = eot;
        end else begin
            e.data   = data;
            e.last   = (idx == words - 1);
            e.nbytes = e.last ? nbytes_t'(left) : nbytes_t'(4);
            e.eot    = e.last && eot;
        end
        return e;
    endfunction

    function automatic word_t make_instruction(input opcode_t op);
        word_t w;
        w = '0;
        w[HDR_TYPE_MSB:HDR_TYPE_LSB] = op;
        return w;
    endfunction

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic compare_din(input cipher_din_t act, input cipher_din_t exp, input int idx);
        if (act !== exp) begin
            report_failure($sformatf(
                "Error at %0t: cipher_din %0d data=%h kind=%0d nbytes=%0d last=%b eot=%b, %s",
                $time, idx, act.data, act.kind, act.nbytes, act.last, act.eot,
                $sformatf("expected data=%h kind=%0d nbytes=%0d last=%b eot=%b",
                          exp.data, exp.kind, exp.nbytes, exp.last, exp.eot)));
        end
    endtask

    task automatic compare_out(input out_word_t act, input out_word_t exp, input int idx);
        if (act !== exp) begin
            report_failure($sformatf("Error at %0t: DO word %0d is %h last=%b, expected %h last=%b",
                                     $time, idx, act.data, act.last, exp.data, exp.last));
        end
    endtask

    task automatic check_reset_outputs(input string when);
        if (pdi_ready || sdi_ready || cipher_din_valid || cipher_dout_ready || do_valid) begin
            report_failure($sformatf("Error at %0t: a valid or ready output is high %s",
                                     $time, when));
        end
    endtask

    // Drive one word with an optional gap, hold it until accepted
    task automatic send_word(input logic on_sdi, input word_t w);
        int    gaps;
        int    waited;
        logic  taken;
        string port;
        gaps = 0;
        port = on_sdi ? "SDI" : "PDI";
        if (stall_en) begin
            rng_stim = xorshift32(rng_stim);
            gaps     = int'(rng_stim[1:0]);
        end
        repeat (gaps) @(negedge clk);
        if (on_sdi) begin
            sdi       = w;
            sdi_valid = 1'b1;
        end else begin
            pdi       = w;
            pdi_valid = 1'b1;
        end
        waited = 0;
        taken  = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken  = on_sdi ? sdi_ready : pdi_ready;
            waited = waited + 1;
            if (!taken && (waited >= TIMEOUT)) begin
                report_failure($sformatf("Timeout: the %s word %h was never accepted", port, w));
            end
        end
        @(negedge clk);
        sdi_valid = 1'b0;
        pdi_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while ((din_seen < exp_din.size()) || (do_seen < exp_do.size())) begin
            @(negedge clk);
            waited = waited + 1;
            if (waited >= TIMEOUT) begin
                report_failure("Timeout: expected cipher_din or DO transfers did not arrive");
            end
        end
    endtask

    task automatic send_segment(input logic on_sdi, input din_kind_e kind, input int len,
                                input logic eot, input logic first_of_hash);
        word_t hdr;
        word_t w;
        int    words;
        int    i;
        hdr = '0;
        hdr[HDR_TYPE_MSB:HDR_TYPE_LSB] = (kind == DIN_KEY) ? SEG_TYPE_KEY : SEG_TYPE_MSG;
        hdr[HDR_EOT_BIT]               = eot;
        hdr[HDR_LAST_BIT]              = eot;
        hdr[HDR_LEN_MSB:HDR_LEN_LSB]   = length_t'(len);
        words = (len + 3) / 4;
        if (len == 0) begin
            exp_din.push_back(expected_din('0, kind, 0, 0, eot));
        end
        send_word(on_sdi, hdr);
        // Hash header must have left DO before this header was taken
        if (first_of_hash && (do_at_pdi <= do_base)) begin
            report_failure($sformatf("Error at %0t: PDI segment header taken before DO header",
                                     $time));
        end
        for (i = 0; i < words; i++) begin
            rng_stim = xorshift32(rng_stim);
            w        = rng_stim;
            exp_din.push_back(expected_din(w, kind, len, i, eot));
            if (kind == DIN_HASH) begin
                hash_acc = hash_acc ^ w;
            end
            send_word(on_sdi, w);
        end
    endtask

    task automatic run_key(input int len);
        send_word(1'b0, make_instruction(OP_ACTIVATE_KEY));
        send_word(1'b1, make_instruction(OP_LOAD_KEY));
        send_segment(1'b1, DIN_KEY, len, 1'b1, 1'b0);
        wait_drained();
    endtask

    task automatic run_hash();
        out_word_t o;
        int        i;
        hash_acc = '0;
        do_base  = do_seen;
        o        = '0;
        o.data[HDR_TYPE_MSB:HDR_TYPE_LSB] = HDR_HASH_VALUE;
        o.data[HDR_EOT_BIT]               = 1'b1;
        o.data[HDR_LAST_BIT]              = 1'b1;
        o.data[HDR_LEN_MSB:HDR_LEN_LSB]   = HASH_BYTES;
        exp_do.push_back(o);
        send_word(1'b0, make_instruction(OP_HASH));
        send_segment(1'b0, DIN_HASH, 5, 1'b0, 1'b1);
        send_segment(1'b0, DIN_HASH, 4, 1'b0, 1'b0);
        send_segment(1'b0, DIN_HASH, 0, 1'b0, 1'b0);
        send_segment(1'b0, DIN_HASH, 9, 1'b1, 1'b0);
        for (i = 0; i < 8; i++) begin
            o.data = hash_acc + word_t'(i);
            o.last = 1'b0;
            exp_do.push_back(o);
        end
        o      = '0;
        o.data[HDR_TYPE_MSB:HDR_TYPE_LSB] = STATUS_SUCCESS;
        o.last = 1'b1;
        exp_do.push_back(o);
        wait_drained();
    endtask

    // Cipher model and monitor, sampled on the rising edge
    always @(posedge clk) begin : capture
        out_word_t h;
        word_t     x;
        int        i;
        if (rst) begin
            if (pdi_valid && pdi_ready) begin
                do_at_pdi = do_seen;
            end
            if (cipher_din_valid && cipher_din_ready) begin
                if (din_seen >= exp_din.size()) begin
                    report_failure($sformatf("Unexpected cipher_din transfer at %0t", $time));
                end else begin
                    compare_din(cipher_din, exp_din[din_seen], din_seen);
                end
                din_seen = din_seen + 1;
                if (cipher_din.kind == DIN_HASH) begin
                    x = model_acc ^ cipher_din.data;
                    model_acc = x;
                    if (cipher_din.eot) begin
                        for (i = 0; i < 8; i++) begin
                            h.data = x + word_t'(i);
                            h.last = (i == 7);
                            model_out.push_back(h);
                        end
                        model_acc = '0;
                    end
                end
            end
            if (cipher_dout_valid && cipher_dout_ready) begin
                model_rd = model_rd + 1;
            end
            if (do_valid && do_ready) begin
                if (do_seen >= exp_do.size()) begin
                    report_failure($sformatf("Unexpected DO transfer at %0t", $time));
                end else begin
                    compare_out(do_word, exp_do[do_seen], do_seen);
                end
                do_seen = do_seen + 1;
            end
        end
    end

    // Ready stalls and cipher output on the falling edge
    always @(negedge clk) begin
        rng_bp           = xorshift32(rng_bp);
        cipher_din_ready = stall_en ? (rng_bp[1:0] != 2'b00) : 1'b1;
        do_ready         = stall_en ? (rng_bp[3:2] != 2'b00) : 1'b1;
        if (model_rd < model_out.size()) begin
            cipher_dout       = model_out[model_rd];
            cipher_dout_valid = 1'b1;
        end else begin
            cipher_dout_valid = 1'b0;
        end
    end

    initial begin
        int i;
        $timeformat(-9, 0, " ns", 0);
        rst       = 1'b0;
        pdi       = '0;
        pdi_valid = 1'b0;
        sdi       = '0;
        sdi_valid = 1'b0;
        stall_en  = 1'b0;
        rng_stim  = SEED;
        hash_acc  = '0;
        do_base   = 0;
        for (i = 0; i < 3; i++) begin
            @(negedge clk);
            check_reset_outputs("during reset");
        end
        rst = 1'b1;
        #1;
        check_reset_outputs("in the first cycle after reset");
        @(negedge clk);

        run_key(16);
        run_key(0);
        run_hash();

        // Same sequences under random stalls and gaps
        @(posedge clk);
        stall_en = 1'b1;
        @(negedge clk);
        run_key(16);
        run_key(0);
        run_hash();

        // Unknown opcode, then a wrong SDI word after key activation
        send_word(1'b0, make_instruction(4'hf));
        send_word(1'b0, make_instruction(OP_ACTIVATE_KEY));
        send_word(1'b1, make_instruction(OP_HASH));
        repeat (5) @(negedge clk);
        run_hash();

        repeat (10) @(negedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== gimli_lwc_ctrl.f ====
src/lwc_api_pkg.sv
src/lwc_ctrl_pkg.sv
src/lwc_segment_loader.sv
src/lwc_operation_flow.sv
src/lwc_do_writer.sv
src/lwc_ctrl_top.sv
tb/lwc_ctrl_chk.sv
tb/lwc_ctrl_tb.sv

// ==== Makefile ====
# Verilator build and run of the LWC controller testbench

VERILATOR ?= verilator
TOP       ?= lwc_ctrl_tb
FILELIST  ?= gimli_lwc_ctrl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
